//--- logic/pipe_cfg.svh
`ifndef PIPE_CFG_SVH
`define PIPE_CFG_SVH

// operand and result width
`define DATA_W 16

// operation tag, also the redirect target
`define TAG_W 4

// data memory words, addressed by the low bits of operand a
`define DMEM_DEPTH 16

// multiply occupancy of execute, in cycles
`define MUL_CYCLES 3

// cycles a load sits in memory before its result is offered
`define LOAD_CYCLES 2

`endif

//--- logic/pipe_pkg.sv
`include "pipe_cfg.svh"

package pipe_pkg;

	typedef logic [`DATA_W-1:0] data_t;
	typedef logic [`TAG_W-1:0] tag_t;
	typedef logic [$clog2(`DMEM_DEPTH)-1:0] addr_t;

	typedef enum logic [2:0] {
		op_add   = 3'd0,
		op_mul   = 3'd1,
		op_bnez  = 3'd2, // one delay slot
		op_load  = 3'd3,
		op_store = 3'd4,
		op_trap  = 3'd5
	} op_e;

	typedef enum logic {
		mul_idle,
		mul_busy
	} mul_state_e;

endpackage

//--- logic/fetch_stage.sv
`include "pipe_cfg.svh"

module fetch_stage import pipe_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  op_valid_i,
	output logic  op_ready_o,
	input  op_e   op_kind_i,
	input  tag_t  op_tag_i,
	input  data_t op_a_i,
	input  data_t op_b_i,
	input  logic  stall_i,
	input  logic  flush_i,
	input  logic  redirect_i,
	input  tag_t  redirect_target_i,
	output logic  if_valid_o,
	output op_e   if_kind_o,
	output tag_t  if_tag_o,
	output data_t if_a_o,
	output data_t if_b_o
);

logic valid_q, en_q, pending_q;
logic [`TAG_W-1:0] target_q;
logic keep, squash, filt_on, take, match, load;
tag_t filt_tag;

// the register may already hold the target op, then it survives the redirect
assign keep = redirect_i & valid_q & (if_tag_o == redirect_target_i);
assign squash = flush_i & ~keep;
assign if_valid_o = valid_q & ~squash;

assign filt_on = redirect_i ? ~keep : pending_q;
assign filt_tag = redirect_i ? redirect_target_i : target_q;

assign op_ready_o = en_q & (~valid_q | ~stall_i | squash);
assign take = op_valid_i & op_ready_o;
assign match = (op_tag_i == filt_tag);
assign load = take & (~filt_on | match); // mismatches are taken and dropped

always_ff @(posedge clk) begin
	if (rst) begin
		en_q <= 1'b0;
		valid_q <= 1'b0;
		pending_q <= 1'b0;
	end else begin
		en_q <= 1'b1;
		if (load)
			valid_q <= 1'b1;
		else if (~stall_i | squash)
			valid_q <= 1'b0;
		pending_q <= filt_on & ~(take & match);
	end
end

always_ff @(posedge clk) begin
	if (load) begin
		if_kind_o <= op_kind_i;
		if_tag_o <= op_tag_i;
		if_a_o <= op_a_i;
		if_b_o <= op_b_i;
	end
	if (redirect_i)
		target_q <= redirect_target_i;
end

endmodule

//--- logic/decode_stage.sv
module decode_stage import pipe_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  stall_i,
	input  logic  flush_i,
	input  logic  if_valid_i,
	input  op_e   if_kind_i,
	input  tag_t  if_tag_i,
	input  data_t if_a_i,
	input  data_t if_b_i,
	output logic  id_valid_o,
	output tag_t  id_tag_o,
	output data_t id_a_o,
	output data_t id_b_o,
	output logic  id_is_mul_o,
	output logic  id_is_branch_o,
	output logic  id_is_load_o,
	output logic  id_is_store_o,
	output logic  id_is_trap_o,
	output addr_t id_addr_o
);

logic [4:0] ctl; // mul, branch, load, store, trap

always_comb begin
	case (if_kind_i)
		op_mul:   ctl = 5'b10000;
		op_bnez:  ctl = 5'b01000;
		op_load:  ctl = 5'b00100;
		op_store: ctl = 5'b00010;
		op_trap:  ctl = 5'b00001;
		default:  ctl = 5'b00000; // add
	endcase
end

always_ff @(posedge clk) begin
	if (rst | flush_i)
		id_valid_o <= 1'b0;
	else if (~stall_i)
		id_valid_o <= if_valid_i;
end

always_ff @(posedge clk) begin
	if (~stall_i) begin
		id_tag_o <= if_tag_i;
		id_a_o <= if_a_i;
		id_b_o <= if_b_i;
		{id_is_mul_o, id_is_branch_o, id_is_load_o, id_is_store_o, id_is_trap_o} <= ctl;
		id_addr_o <= addr_t'(if_a_i);
	end
end

endmodule

//--- logic/exec_stage.sv
`include "pipe_cfg.svh"

module exec_stage import pipe_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  stall_i,
	input  logic  flush_i,
	input  logic  id_valid_i,
	input  tag_t  id_tag_i,
	input  data_t id_a_i,
	input  data_t id_b_i,
	input  logic  id_is_mul_i,
	input  logic  id_is_branch_i,
	input  logic  id_is_load_i,
	input  logic  id_is_store_i,
	input  logic  id_is_trap_i,
	input  addr_t id_addr_i,
	output logic  stall_from_ex_o,
	output logic  br_valid_o,
	output logic  br_taken_o,
	output tag_t  br_target_o,
	output logic  ex_valid_o,
	output tag_t  ex_tag_o,
	output data_t ex_result_o,
	output addr_t ex_addr_o,
	output data_t ex_wdata_o,
	output logic  ex_is_load_o,
	output logic  ex_is_store_o,
	output logic  ex_is_trap_o
);

localparam int CNT_W = $clog2(`MUL_CYCLES + 1);

logic ex_valid_q, is_mul_q, is_branch_q;
data_t a_q, b_q, product;
mul_state_e mul_state;
logic [CNT_W-1:0] mul_cnt;
logic mul_done;

always_ff @(posedge clk) begin
	if (rst | flush_i)
		ex_valid_q <= 1'b0;
	else if (~stall_i)
		ex_valid_q <= id_valid_i;
end

always_ff @(posedge clk) begin
	if (~stall_i) begin
		ex_tag_o <= id_tag_i;
		a_q <= id_a_i;
		b_q <= id_b_i;
		is_mul_q <= id_is_mul_i;
		is_branch_q <= id_is_branch_i;
		ex_is_load_o <= id_is_load_i;
		ex_is_store_o <= id_is_store_i;
		ex_is_trap_o <= id_is_trap_i;
		ex_addr_o <= id_addr_i;
	end
end

// multiply occupies execute for MUL_CYCLES, counted from 0 while idle
assign mul_done = ex_valid_q & is_mul_q & (mul_cnt == CNT_W'(`MUL_CYCLES - 1));
assign stall_from_ex_o = ex_valid_q & is_mul_q & ~mul_done;

always_ff @(posedge clk) begin
	if (rst | flush_i) begin
		mul_state <= mul_idle;
		mul_cnt <= '0;
	end else begin
		case (mul_state)
			mul_idle: if (stall_from_ex_o) begin
				mul_state <= mul_busy;
				mul_cnt <= CNT_W'(1);
			end
			mul_busy: if (~mul_done) begin
				mul_cnt <= mul_cnt + 1'b1;
			end else if (~stall_i) begin
				mul_state <= mul_idle; // product leaves for memory
				mul_cnt <= '0;
			end
			default: mul_state <= mul_idle;
		endcase
	end
end

assign product = a_q * b_q; // low half only
assign br_valid_o = ex_valid_q & is_branch_q;
assign br_taken_o = (a_q != '0);
assign br_target_o = b_q[`TAG_W-1:0];

always_comb begin
	if (is_mul_q)
		ex_result_o = product;
	else if (is_branch_q)
		ex_result_o = data_t'(br_taken_o);
	else if (ex_is_store_o)
		ex_result_o = b_q;
	else if (ex_is_trap_o)
		ex_result_o = a_q;
	else
		ex_result_o = a_q + b_q;
end

assign ex_wdata_o = b_q; // store data, or trap target for memory
assign ex_valid_o = ex_valid_q & ~stall_i & ~flush_i; // bubble when held or squashed

endmodule

//--- logic/mem_stage.sv
`include "pipe_cfg.svh"

module mem_stage import pipe_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  stall_i,
	input  logic  ex_valid_i,
	input  tag_t  ex_tag_i,
	input  data_t ex_result_i,
	input  addr_t ex_addr_i,
	input  data_t ex_wdata_i,
	input  logic  ex_is_load_i,
	input  logic  ex_is_store_i,
	input  logic  ex_is_trap_i,
	output logic  stall_from_mm_o,
	output logic  trap_valid_o,
	output tag_t  trap_target_o,
	output logic  res_valid_o,
	input  logic  res_ready_i,
	output tag_t  res_tag_o,
	output data_t res_data_o,
	output logic  res_exc_o
);

localparam int LCNT_W = $clog2(`LOAD_CYCLES + 1);

data_t dmem [`DMEM_DEPTH];
logic mm_valid, mm_is_load, mm_is_store, mm_is_trap;
data_t mm_result, mm_wdata;
addr_t mm_addr;
logic [LCNT_W-1:0] ld_cnt;
logic ld_done, xfer;

assign ld_done = (ld_cnt == LCNT_W'(`LOAD_CYCLES - 1));
assign res_valid_o = mm_valid & (~mm_is_load | ld_done);
assign xfer = res_valid_o & res_ready_i;
assign stall_from_mm_o = mm_valid & ~xfer; // counting load or back-pressure

assign trap_valid_o = xfer & mm_is_trap;
assign trap_target_o = mm_wdata[`TAG_W-1:0];
assign res_data_o = mm_is_load ? dmem[mm_addr] : mm_result;
assign res_exc_o = mm_is_trap;

always_ff @(posedge clk) begin
	if (rst) begin
		mm_valid <= 1'b0;
		ld_cnt <= '0;
	end else if (~stall_i) begin
		mm_valid <= ex_valid_i;
		ld_cnt <= '0;
	end else if (mm_is_load & ~ld_done) begin
		ld_cnt <= ld_cnt + 1'b1;
	end
end

always_ff @(posedge clk) begin
	if (~stall_i) begin
		res_tag_o <= ex_tag_i;
		mm_result <= ex_result_i;
		mm_wdata <= ex_wdata_i;
		mm_addr <= ex_addr_i;
		mm_is_load <= ex_is_load_i;
		mm_is_store <= ex_is_store_i;
		mm_is_trap <= ex_is_trap_i;
	end
end

// stores commit only when their result is taken
always_ff @(posedge clk) begin
	if (rst) begin
		for (int i = 0; i < `DMEM_DEPTH; i++)
			dmem[i] <= '0;
	end else if (xfer & mm_is_store) begin
		dmem[mm_addr] <= mm_wdata;
	end
end

endmodule

//--- logic/hazard_ctrl.sv
module hazard_ctrl import pipe_pkg::*; (
	input  logic rst,
	input  logic stall_from_ex_i,
	input  logic stall_from_mm_i,
	input  logic br_valid_i,
	input  logic br_taken_i,
	input  tag_t br_target_i,
	input  logic id_valid_i,
	input  logic trap_valid_i,
	input  tag_t trap_target_i,
	output logic stall_if_o,
	output logic stall_id_o,
	output logic stall_ex_o,
	output logic stall_mm_o,
	output logic flush_if_o,
	output logic flush_id_o,
	output logic flush_ex_o,
	output logic redirect_o,
	output tag_t redirect_target_o
);

logic [3:0] stall;
logic [2:0] flush;
logic wait_delayslot, flush_branch;

assign {stall_if_o, stall_id_o, stall_ex_o, stall_mm_o} = stall;
assign {flush_if_o, flush_id_o, flush_ex_o} = flush;

assign wait_delayslot = br_valid_i & ~id_valid_i;

// resolve only when the branch and its delay slot both move on
assign flush_branch = br_valid_i & br_taken_i & id_valid_i
	& ~stall_from_ex_i
	& ~stall_ex_o;

always_comb begin
	if (rst)
		stall = 4'b1111;
	else if (stall_from_mm_i)
		stall = 4'b1111;
	else if (stall_from_ex_i)
		stall = 4'b1110; // memory takes a bubble
	else if (wait_delayslot)
		stall = 4'b0010;
	else
		stall = 4'b0000;
end

always_comb begin
	flush = 3'b000;
	if (trap_valid_i)
		flush = 3'b111;
	else if (flush_branch)
		flush = 3'b100; // delay slot passes
end

assign redirect_o = trap_valid_i | flush_branch;
assign redirect_target_o = trap_valid_i ? trap_target_i : br_target_i;

endmodule

//--- logic/op_pipe_top.sv
module op_pipe_top import pipe_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  op_valid_i,
	output logic  op_ready_o,
	input  op_e   op_kind_i,
	input  tag_t  op_tag_i,
	input  data_t op_a_i,
	input  data_t op_b_i,
	output logic  res_valid_o,
	input  logic  res_ready_i,
	output tag_t  res_tag_o,
	output data_t res_data_o,
	output logic  res_exc_o
);

logic if_valid, id_valid, ex_valid;
op_e if_kind;
tag_t if_tag, id_tag, ex_tag, br_target, trap_target, redirect_target;
data_t if_a, if_b, id_a, id_b, ex_result, ex_wdata;
addr_t id_addr, ex_addr;
logic id_is_mul, id_is_branch, id_is_load, id_is_store, id_is_trap;
logic ex_is_load, ex_is_store, ex_is_trap;
logic stall_from_ex, stall_from_mm, br_valid, br_taken, trap_valid;
logic stall_if, stall_id, stall_ex, stall_mm, flush_if, flush_id, flush_ex, redirect;

fetch_stage u_fetch (
	.clk, .rst, .op_valid_i, .op_ready_o, .op_kind_i, .op_tag_i, .op_a_i, .op_b_i,
	.stall_i(stall_if), .flush_i(flush_if), .redirect_i(redirect),
	.redirect_target_i(redirect_target),
	.if_valid_o(if_valid), .if_kind_o(if_kind), .if_tag_o(if_tag), .if_a_o(if_a), .if_b_o(if_b)
);

decode_stage u_decode (
	.clk, .rst, .stall_i(stall_id), .flush_i(flush_id),
	.if_valid_i(if_valid), .if_kind_i(if_kind), .if_tag_i(if_tag), .if_a_i(if_a), .if_b_i(if_b),
	.id_valid_o(id_valid), .id_tag_o(id_tag), .id_a_o(id_a), .id_b_o(id_b),
	.id_is_mul_o(id_is_mul), .id_is_branch_o(id_is_branch), .id_is_load_o(id_is_load),
	.id_is_store_o(id_is_store), .id_is_trap_o(id_is_trap), .id_addr_o(id_addr)
);

exec_stage u_exec (
	.clk, .rst, .stall_i(stall_ex), .flush_i(flush_ex),
	.id_valid_i(id_valid), .id_tag_i(id_tag), .id_a_i(id_a), .id_b_i(id_b),
	.id_is_mul_i(id_is_mul), .id_is_branch_i(id_is_branch), .id_is_load_i(id_is_load),
	.id_is_store_i(id_is_store), .id_is_trap_i(id_is_trap), .id_addr_i(id_addr),
	.stall_from_ex_o(stall_from_ex), .br_valid_o(br_valid), .br_taken_o(br_taken),
	.br_target_o(br_target), .ex_valid_o(ex_valid), .ex_tag_o(ex_tag),
	.ex_result_o(ex_result), .ex_addr_o(ex_addr), .ex_wdata_o(ex_wdata),
	.ex_is_load_o(ex_is_load), .ex_is_store_o(ex_is_store), .ex_is_trap_o(ex_is_trap)
);

mem_stage u_mem (
	.clk, .rst, .stall_i(stall_mm),
	.ex_valid_i(ex_valid), .ex_tag_i(ex_tag), .ex_result_i(ex_result), .ex_addr_i(ex_addr),
	.ex_wdata_i(ex_wdata), .ex_is_load_i(ex_is_load), .ex_is_store_i(ex_is_store),
	.ex_is_trap_i(ex_is_trap), .stall_from_mm_o(stall_from_mm),
	.trap_valid_o(trap_valid), .trap_target_o(trap_target),
	.res_valid_o, .res_ready_i, .res_tag_o, .res_data_o, .res_exc_o
);

hazard_ctrl u_ctrl (
	.rst, .stall_from_ex_i(stall_from_ex), .stall_from_mm_i(stall_from_mm),
	.br_valid_i(br_valid), .br_taken_i(br_taken), .br_target_i(br_target),
	.id_valid_i(id_valid), .trap_valid_i(trap_valid), .trap_target_i(trap_target),
	.stall_if_o(stall_if), .stall_id_o(stall_id), .stall_ex_o(stall_ex), .stall_mm_o(stall_mm),
	.flush_if_o(flush_if), .flush_id_o(flush_id), .flush_ex_o(flush_ex),
	.redirect_o(redirect), .redirect_target_o(redirect_target)
);

endmodule

//--- tests/op_pipe_sva.sv
module op_pipe_sva import pipe_pkg::*; (
	input logic       clk,
	input logic       rst,
	input logic       op_ready_i,
	input logic       res_valid_i,
	input logic       res_ready_i,
	input tag_t       res_tag_i,
	input data_t      res_data_i,
	input logic       res_exc_i,
	input mul_state_e mul_state_i,
	input logic       ex_valid_i
);

timeunit 1ns;
timeprecision 100ps;

// a held result keeps valid and payload until it is taken
assert property (@(posedge clk) disable iff (rst)
	res_valid_i && !res_ready_i |=> res_valid_i && $stable(res_tag_i)
		&& $stable(res_data_i) && $stable(res_exc_i))
	else $error("result changed while held by back-pressure");

// reset is synchronous, so ready drops from the second reset edge on
assert property (@(posedge clk) rst && $past(rst) |-> !op_ready_i)
	else $error("op_ready_o high during reset");

assert property (@(posedge clk) disable iff (rst)
	mul_state_i == mul_busy |-> ex_valid_i)
	else $error("multiplier busy with an empty execute register");

endmodule

bind op_pipe_top op_pipe_sva u_sva (
	.clk,
	.rst,
	.op_ready_i(op_ready_o),
	.res_valid_i(res_valid_o),
	.res_ready_i(res_ready_i),
	.res_tag_i(res_tag_o),
	.res_data_i(res_data_o),
	.res_exc_i(res_exc_o),
	.mul_state_i(u_exec.mul_state),
	.ex_valid_i(u_exec.ex_valid_q)
);

//--- tests/op_pipe_tb.sv
`include "pipe_cfg.svh"

module op_pipe_tb import pipe_pkg::*; ();

timeunit 1ns;
timeprecision 100ps;

localparam int TIMEOUT = 40 * `MUL_CYCLES; // cycles per wait

logic clk = 1'b0;
logic rst;
logic op_valid_i, op_ready_o;
op_e op_kind_i;
tag_t op_tag_i;
data_t op_a_i, op_b_i;
logic res_valid_o, res_ready_i;
tag_t res_tag_o;
data_t res_data_o;
logic res_exc_o;

logic rand_ready = 1'b0;
logic [15:0] lfsr_q = 16'd7;

op_e kind_q[$];
tag_t tag_q[$];
data_t opa_q[$], opb_q[$];
tag_t exp_tag_q[$];
data_t exp_data_q[$];
logic exp_exc_q[$];
data_t model_mem [`DMEM_DEPTH];

int n_checks = 0;
int n_value_err = 0;
int n_other_err = 0;

op_pipe_top u_dut (
	.clk(clk), .rst(rst),
	.op_valid_i(op_valid_i), .op_ready_o(op_ready_o), .op_kind_i(op_kind_i),
	.op_tag_i(op_tag_i), .op_a_i(op_a_i), .op_b_i(op_b_i),
	.res_valid_o(res_valid_o), .res_ready_i(res_ready_i), .res_tag_o(res_tag_o),
	.res_data_o(res_data_o), .res_exc_o(res_exc_o)
);

always #20 clk = ~clk;

function automatic logic [15:0] lfsr_step(input logic [15:0] s);
	return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

// result sink, ready is one lfsr bit per cycle when randomized
always @(posedge clk) begin
	if (rand_ready) begin
		lfsr_q = lfsr_step(lfsr_q);
		res_ready_i <= lfsr_q[0];
	end else begin
		res_ready_i <= 1'b1;
	end
end

task automatic check_data(input string name, input data_t got, input data_t exp);
	n_checks++;
	if (got !== exp) begin
		$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
		n_value_err++;
	end
endtask

task automatic check_tag(input string name, input tag_t got, input tag_t exp);
	n_checks++;
	if (got !== exp) begin
		$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
		n_value_err++;
	end
endtask

task automatic check_exc(input string name, input logic got, input logic exp);
	n_checks++;
	if (got !== exp) begin
		$display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
		n_value_err++;
	end
endtask

task automatic push_op(input op_e k, input tag_t t, input data_t a, input data_t b);
	kind_q.push_back(k);
	tag_q.push_back(t);
	opa_q.push_back(a);
	opb_q.push_back(b);
endtask

// reference model: in order, delay slot runs, then fetch skips to the target tag
task automatic predict();
	int i;
	logic skipping, slot_next, exc;
	tag_t target, slot_target;
	data_t res;
	logic [2*`DATA_W-1:0] prod;
	skipping = 1'b0;
	slot_next = 1'b0;
	target = '0;
	slot_target = '0;
	for (i = 0; i < kind_q.size(); i++) begin
		if (!skipping || tag_q[i] == target) begin
			skipping = 1'b0;
			exc = 1'b0;
			case (kind_q[i])
				op_mul: begin
					prod = opa_q[i] * opb_q[i];
					res = prod[`DATA_W-1:0];
				end
				op_bnez:  res = data_t'(opa_q[i] != '0);
				op_load:  res = model_mem[addr_t'(opa_q[i])];
				op_store: begin
					model_mem[addr_t'(opa_q[i])] = opb_q[i];
					res = opb_q[i];
				end
				op_trap: begin
					res = opa_q[i];
					exc = 1'b1;
				end
				default:  res = opa_q[i] + opb_q[i];
			endcase
			exp_tag_q.push_back(tag_q[i]);
			exp_data_q.push_back(res);
			exp_exc_q.push_back(exc);
			if (slot_next) begin
				skipping = 1'b1; // branch takes effect after its delay slot
				target = slot_target;
				slot_next = 1'b0;
			end else if (kind_q[i] == op_bnez && opa_q[i] != '0) begin
				slot_next = 1'b1;
				slot_target = opb_q[i][`TAG_W-1:0];
			end
			if (kind_q[i] == op_trap) begin
				skipping = 1'b1;
				target = opb_q[i][`TAG_W-1:0];
			end
		end
	end
endtask

task automatic send_ops();
	int i;
	int waited;
	for (i = 0; i < kind_q.size(); i++) begin
		@(posedge clk);
		op_valid_i <= 1'b1;
		op_kind_i <= kind_q[i];
		op_tag_i <= tag_q[i];
		op_a_i <= opa_q[i];
		op_b_i <= opb_q[i];
		waited = 0;
		@(negedge clk);
		while (!op_ready_o && waited < TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (!op_ready_o) begin
			$display("op_ready_o stayed low too long, tag %0d was not accepted", tag_q[i]);
			n_other_err++;
		end
	end
	@(posedge clk);
	op_valid_i <= 1'b0;
endtask

task automatic collect_results();
	int idle;
	idle = 0;
	while (exp_tag_q.size() > 0 && idle < TIMEOUT) begin
		@(negedge clk);
		if (res_valid_o && res_ready_i) begin // transfer at the next edge
			check_tag("res_tag_o", res_tag_o, exp_tag_q.pop_front());
			check_data("res_data_o", res_data_o, exp_data_q.pop_front());
			check_exc("res_exc_o", res_exc_o, exp_exc_q.pop_front());
			idle = 0;
		end else begin
			idle++;
		end
	end
	if (exp_tag_q.size() > 0) begin
		$display("timed out waiting for results, %0d still missing", exp_tag_q.size());
		n_other_err++;
		exp_tag_q.delete();
		exp_data_q.delete();
		exp_exc_q.delete();
	end
	@(posedge clk);
endtask

task automatic quiet_check();
	int n;
	for (n = 0; n < 6; n++) begin
		@(negedge clk);
		if (res_valid_o) begin
			$display("extra result with tag %0d offered at %0t", res_tag_o, $time);
			n_other_err++;
		end
	end
endtask

task automatic run_stream();
	predict();
	fork
		send_ops();
		collect_results();
	join
	quiet_check();
	kind_q.delete();
	tag_q.delete();
	opa_q.delete();
	opb_q.delete();
endtask

task automatic apply_reset();
	int n;
	@(posedge clk);
	rst <= 1'b1;
	op_valid_i <= 1'b0;
	for (n = 0; n < 8; n++) begin
		@(posedge clk);
		if (n == 7)
			rst <= 1'b0;
		@(negedge clk);
		if (op_ready_o !== 1'b0 || res_valid_o !== 1'b0) begin
			$display("handshake outputs not low in reset cycle %0d", n);
			n_other_err++;
		end
	end
	for (n = 0; n < `DMEM_DEPTH; n++)
		model_mem[n] = '0;
endtask

task automatic arith_seq();
	push_op(op_add, 4'd0, 16'h0003, 16'h0004);
	push_op(op_mul, 4'd1, 16'h0012, 16'h0034);
	push_op(op_mul, 4'd2, 16'h1234, 16'h5678); // only the low half survives
	push_op(op_add, 4'd3, 16'hffff, 16'h0002);
	push_op(op_mul, 4'd4, 16'd7, 16'd9);
	push_op(op_add, 4'd5, 16'h0100, 16'h0023);
	run_stream();
endtask

task automatic store_load_seq();
	push_op(op_store, 4'd0, 16'd1, 16'h1111);
	push_op(op_store, 4'd1, 16'd2, 16'h2222);
	push_op(op_load, 4'd2, 16'd1, 16'h0000);
	push_op(op_store, 4'd3, 16'd2, 16'h2b2b);
	push_op(op_load, 4'd4, 16'd2, 16'h0000);
	push_op(op_load, 4'd5, 16'd7, 16'h0000); // never written
	push_op(op_store, 4'd6, 16'd3, 16'h3333);
	push_op(op_load, 4'd7, 16'd3, 16'h0000);
	push_op(op_load, 4'd8, 16'd2, 16'h0000);
	run_stream();
endtask

task automatic branch_seq();
	push_op(op_add, 4'd0, 16'd1, 16'd2);
	push_op(op_bnez, 4'd1, 16'd1, 16'd6);
	push_op(op_add, 4'd2, 16'd3, 16'd3);
	push_op(op_add, 4'd3, 16'd9, 16'd9);
	push_op(op_mul, 4'd4, 16'd5, 16'd5);
	push_op(op_add, 4'd5, 16'd8, 16'd8);
	push_op(op_add, 4'd6, 16'h0060, 16'h0006);
	push_op(op_bnez, 4'd7, 16'd0, 16'd2); // not taken
	push_op(op_add, 4'd8, 16'd8, 16'd1);
	push_op(op_add, 4'd9, 16'd9, 16'd1);
	push_op(op_bnez, 4'd10, 16'd5, 16'd12);
	push_op(op_add, 4'd11, 16'd11, 16'd1);
	push_op(op_add, 4'd12, 16'd12, 16'd1);
	push_op(op_add, 4'd13, 16'd13, 16'd1);
	run_stream();
endtask

task automatic trap_seq();
	push_op(op_add, 4'd0, 16'd4, 16'd4);
	push_op(op_trap, 4'd1, 16'h1234, 16'h0009);
	push_op(op_add, 4'd2, 16'd2, 16'd2);
	push_op(op_store, 4'd3, 16'd3, 16'hdead); // squashed, memory keeps its word
	push_op(op_mul, 4'd4, 16'd4, 16'd4);
	push_op(op_add, 4'd5, 16'd5, 16'd5);
	push_op(op_add, 4'd9, 16'd1, 16'd1);
	push_op(op_load, 4'd10, 16'd3, 16'h0000);
	push_op(op_add, 4'd11, 16'd11, 16'd11);
	run_stream();
endtask

task automatic mixed_backpressure();
	rand_ready <= 1'b1;
	push_op(op_store, 4'd0, 16'd5, 16'h0a0a);
	push_op(op_mul, 4'd1, 16'd3, 16'd5);
	push_op(op_load, 4'd2, 16'd5, 16'h0000);
	push_op(op_bnez, 4'd3, 16'd2, 16'd7);
	push_op(op_add, 4'd4, 16'd4, 16'd4);
	push_op(op_add, 4'd5, 16'd5, 16'd5);
	push_op(op_load, 4'd6, 16'd1, 16'h0000);
	push_op(op_mul, 4'd7, 16'h0101, 16'h0202);
	push_op(op_trap, 4'd8, 16'h00ff, 16'h000e);
	push_op(op_add, 4'd9, 16'd9, 16'd9);
	push_op(op_add, 4'd10, 16'd10, 16'd10);
	push_op(op_add, 4'd11, 16'd11, 16'd11);
	push_op(op_add, 4'd12, 16'd12, 16'd12);
	push_op(op_add, 4'd14, 16'd14, 16'd14);
	push_op(op_load, 4'd15, 16'd1, 16'h0000);
	push_op(op_add, 4'd0, 16'hfff0, 16'h0020);
	push_op(op_mul, 4'd1, 16'h00ff, 16'h0011);
	run_stream();
	rand_ready <= 1'b0;
endtask

task automatic reset_recovery();
	apply_reset();
	push_op(op_load, 4'd0, 16'd3, 16'h0000); // written before the reset
	push_op(op_load, 4'd1, 16'd5, 16'h0000);
	push_op(op_add, 4'd2, 16'd6, 16'd7);
	run_stream();
endtask

initial begin
	rst = 1'b1;
	op_valid_i = 1'b0;
	op_kind_i = op_add;
	op_tag_i = '0;
	op_a_i = '0;
	op_b_i = '0;
	res_ready_i = 1'b0;
	apply_reset();
	arith_seq();
	store_load_seq();
	branch_seq();
	trap_seq();
	mixed_backpressure();
	reset_recovery();
	$display("checks %0d, value mismatches %0d, other failures %0d",
		n_checks, n_value_err, n_other_err);
	if (n_value_err == 0 && n_other_err == 0)
		$display("RESULT: PASS");
	else
		$display("RESULT: FAIL");
	$finish;
end

endmodule

//--- compile.f
+incdir+logic
logic/pipe_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/exec_stage.sv
logic/mem_stage.sv
logic/hazard_ctrl.sv
logic/op_pipe_top.sv
tests/op_pipe_sva.sv
tests/op_pipe_tb.sv
